//--- Bender.yml
package:
  name: uart_hub

export_include_dirs:
  - source

sources:
  - include_dirs:
      - source
    files:
      - source/uart_hub_pkg.sv
      - source/rx_record_if.sv
      - source/uart_baud_tick.sv
      - source/uart_frame_rx.sv
      - source/rx_buffer_arbiter.sv
      - source/rx_fifo.sv
      - source/uart_hub.sv
  - target: simulation
    include_dirs:
      - source
    files:
      - dv/uart_hub_tb.sv

//--- dv/uart_hub_tb.sv
`timescale 1ns/10ps
`include "uart_hub_settings.svh"

module uart_hub_tb;

	// Clocks per serial bit, 64 by default
	localparam int BIT_CLKS = `UART_HUB_BAUD_DIV * `UART_HUB_OVERSAMPLE;
	localparam int GAP_CLKS = 16;
	// Quarter bit low pulse ends well before the mid start sample
	localparam int GLITCH_CLKS = BIT_CLKS / 4;
	localparam int DRAIN_TIMEOUT = 4000;
	localparam int CHAN_BIT = 8;

	// Host ready modes
	localparam int READY_HIGH = 0;
	localparam int READY_RANDOM = 1;
	localparam int READY_LOW = 2;

	logic                                clk;
	logic                                reset;
	logic [`UART_HUB_CHANNELS-1:0]       rx;
	logic                                out_valid;
	logic                                out_ready;
	uart_hub_pkg::rx_record_t            out_record;

	// Expected records per channel in arrival order
	uart_hub_pkg::rx_record_t exp_q0 [$];
	uart_hub_pkg::rx_record_t exp_q1 [$];

	// Frame entries hold chan at bit 9, stop_good at bit 8 and the byte below
	int par_q0 [$];
	int par_q1 [$];
	int stall_q [$];

	int          ready_mode;
	logic [15:0] lfsr_state;

	uart_hub i_uart_hub
	(
		.clk        (clk),
		.reset      (reset),
		.rx         (rx),
		.out_valid  (out_valid),
		.out_ready  (out_ready),
		.out_record (out_record)
	);

	always #4 clk = ~clk;

	//////////////////////////////////////////////////////////////////////
	// Checking helpers
	//////////////////////////////////////////////////////////////////////

	task automatic report_failure(input string msg);
		$display("%s", msg);
		$display("Checks failed");
		$fatal(1);
	endtask

	task automatic check_value(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		if (got !== exp)
			report_failure($sformatf("** Error at %0t: %s is %0h, expected %0h",
				$time, name, got, exp));
	endtask

	// Record layout from MSB is overrun, framing error, channel and byte
	function automatic uart_hub_pkg::rx_record_t make_record(input int ovr,
		input int stop_good, input int ch, input int data);
		return {ovr[0], ~stop_good[0], uart_hub_pkg::chan_id_t'(ch),
			uart_hub_pkg::data_byte_t'(data)};
	endfunction

	task automatic push_expected(input int ch, input uart_hub_pkg::rx_record_t rec);
		if (ch == 0)
			exp_q0.push_back(rec);
		else
			exp_q1.push_back(rec);
	endtask

	task automatic pop_expected(input int ch, output uart_hub_pkg::rx_record_t rec);
		if (ch == 0 && exp_q0.size() == 0)
			report_failure("record from channel 0 arrived with none expected");
		else if (ch != 0 && exp_q1.size() == 0)
			report_failure("record from channel 1 arrived with none expected");
		else if (ch == 0)
			rec = exp_q0.pop_front();
		else
			rec = exp_q1.pop_front();
	endtask

	// Galois LFSR with taps 16, 14, 13 and 11
	function automatic logic [15:0] lfsr_next(input logic [15:0] s);
		return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
	endfunction

	// One LFSR step per bit taken
	task automatic take_random_bits(input int n, output int value);
		value = 0;
		for (int i = 0; i < n; i++)
		begin
			lfsr_state = lfsr_next(lfsr_state);
			value = (value << 1) | int'(lfsr_state[0]);
		end
	endtask

	//////////////////////////////////////////////////////////////////////
	// Line drivers
	//////////////////////////////////////////////////////////////////////

	// Start bit, 8 data bits LSB first and stop bit, then a short idle gap
	task automatic send_frame(input int entry);
		int ch;
		int bits;
		ch = (entry >> 9) & 1;
		// Stop bit sits above the byte
		bits = ((entry & 'h1ff) << 1);
		for (int i = 0; i < 10; i++)
		begin
			@(negedge clk);
			rx[ch] = bits[i];
			repeat (BIT_CLKS - 1)
				@(negedge clk);
		end
		@(negedge clk);
		rx[ch] = 1'b1;
		repeat (GAP_CLKS)
			@(negedge clk);
	endtask

	// Short low pulse, then two idle bits
	task automatic send_glitch(input int ch);
		@(negedge clk);
		rx[ch] = 1'b0;
		repeat (GLITCH_CLKS)
			@(negedge clk);
		rx[ch] = 1'b1;
		repeat (2 * BIT_CLKS)
			@(negedge clk);
	endtask

	task automatic send_burst(input int ch);
		int entry;
		while ((ch == 0 ? par_q0.size() : par_q1.size()) != 0)
		begin
			entry = (ch == 0) ? par_q0.pop_front() : par_q1.pop_front();
			send_frame(entry);
		end
	endtask

	// Both queues empty and nothing left in the FIFO
	task automatic wait_drain();
		int cycles;
		bit done;
		cycles = 0;
		done = 1'b0;
		while (!done)
		begin
			@(posedge clk);
			cycles++;
			if (exp_q0.size() == 0 && exp_q1.size() == 0 && !out_valid)
				done = 1'b1;
			else if (cycles >= DRAIN_TIMEOUT)
				report_failure("timeout waiting for the expected records to arrive");
		end
	endtask

	//////////////////////////////////////////////////////////////////////
	// Host side
	//////////////////////////////////////////////////////////////////////

	// Stall phases of random length
	initial
	begin : drive_ready
		int phase_left;
		int len;
		int r;
		phase_left = 0;
		forever
		begin
			@(negedge clk);
			if (ready_mode == READY_HIGH)
				out_ready = 1'b1;
			else if (ready_mode == READY_LOW)
				out_ready = 1'b0;
			else if (phase_left == 0)
			begin
				// Ready in three phases out of four
				take_random_bits(5, len);
				take_random_bits(2, r);
				out_ready = (r != 0);
				phase_left = len;
			end
			else
				phase_left--;
		end
	end

	// Sampled at the rising edge before the DUT flops update
	initial
	begin : read_records
		uart_hub_pkg::rx_record_t exp_rec;
		uart_hub_pkg::rx_record_t held_rec;
		logic held;
		held = 1'b0;
		forever
		begin
			@(posedge clk);
			if (!reset)
			begin
				// Stalled head must not change
				if (held)
				begin
					check_value("out_valid", out_valid, 1);
					check_value("out_record", out_record, held_rec);
				end
				if (out_valid && out_ready)
				begin
					pop_expected(int'(out_record[CHAN_BIT]), exp_rec);
					check_value("out_record", out_record, exp_rec);
				end
				held = out_valid & ~out_ready;
				held_rec = out_record;
			end
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Main sequence
	//////////////////////////////////////////////////////////////////////

	initial
	begin : main
		int fd;
		int fields;
		int kind;
		int ch;
		int data;
		int stop_good;
		int ovr;
		int stored;
		int model_ovr;
		int entry;
		bit pend_valid;
		string line;
		uart_hub_pkg::rx_record_t pend_rec;
		clk = 1'b0;
		reset = 1'b1;
		rx = '1;
		out_ready = 1'b0;
		ready_mode = READY_HIGH;
		lfsr_state = 16'd56;
		stored = 0;
		pend_valid = 1'b0;
		repeat (3)
			@(posedge clk);
		@(negedge clk);
		reset = 1'b0;
		check_value("out_valid", out_valid, 0);

		fd = $fopen("dv/uart_hub_tests.txt", "r");
		if (fd == 0)
			report_failure("cannot open dv/uart_hub_tests.txt");
		while (!$feof(fd))
		begin
			line = "";
			void'($fgets(line, fd));
			fields = 0;
			// Skip comment and empty lines
			if (line.len() > 1 && line.getc(0) != "#")
				fields = $sscanf(line, "%d %d %h %d %d", kind, ch, data, stop_good, ovr);
			if (fields == 5)
			begin
				entry = (ch << 9) | (stop_good << 8) | (data & 'hff);
				case (kind)
					0:
					begin
						push_expected(ch, make_record(ovr, stop_good, ch, data));
						send_frame(entry);
						wait_drain();
					end
					1:
					begin
						send_glitch(ch);
						wait_drain();
					end
					2:
					begin
						push_expected(ch, make_record(ovr, stop_good, ch, data));
						if (ch == 0)
							par_q0.push_back(entry);
						else
							par_q1.push_back(entry);
					end
					3:
					begin
						@(posedge clk);
						ready_mode = READY_RANDOM;
						fork
							send_burst(0);
							send_burst(1);
						join
						@(posedge clk);
						ready_mode = READY_HIGH;
						wait_drain();
					end
					4:
					begin
						// FIFO fills first, then one record waits at the receiver
						model_ovr = (stored >= `UART_HUB_FIFO_DEPTH && pend_valid) ? 1 : 0;
						if (ovr != model_ovr)
							report_failure(
								"overrun column in the data file disagrees with the FIFO depth");
						else if (stored < `UART_HUB_FIFO_DEPTH)
						begin
							push_expected(ch, make_record(ovr, stop_good, ch, data));
							stored++;
						end
						else
						begin
							// Newest held record replaces the older one
							pend_rec = make_record(ovr, stop_good, ch, data);
							pend_valid = 1'b1;
						end
						stall_q.push_back(entry);
					end
					5:
					begin
						if (pend_valid)
							push_expected(int'(pend_rec[CHAN_BIT]), pend_rec);
						@(posedge clk);
						ready_mode = READY_LOW;
						while (stall_q.size() != 0)
							send_frame(stall_q.pop_front());
						@(posedge clk);
						ready_mode = READY_HIGH;
						wait_drain();
						stored = 0;
						pend_valid = 1'b0;
					end
					default:
						report_failure("unknown case kind in the data file");
				endcase
			end
		end
		$fclose(fd);

		// Nothing left behind in the hub
		repeat (BIT_CLKS)
			@(posedge clk);
		check_value("out_valid", out_valid, 0);
		$display("All checks passed");
		$finish;
	end

endmodule

//--- dv/uart_hub_tests.txt
# kind chan byte(hex) stop_good overrun
# kind 0 single frame, 1 short low glitch, 2 add to parallel burst, 3 run it
# kind 4 add to stalled burst, 5 run it with out_ready held low
0 0 a5 1 0
0 0 3c 0 0
1 1 00 1 0
0 1 5a 1 0
2 0 11 1 0
2 1 e2 1 0
2 0 22 1 0
2 1 d3 0 0
2 0 33 1 0
2 1 c4 1 0
3 0 00 1 0
4 0 01 1 0
4 0 02 1 0
4 0 03 1 0
4 0 04 1 0
4 0 05 1 0
4 0 06 1 0
4 0 07 1 0
4 0 08 1 0
4 0 09 1 0
4 0 0a 1 1
5 0 00 1 0

//--- source/rx_buffer_arbiter.sv
`timescale 1ns/10ps
`include "uart_hub_settings.svh"

module rx_buffer_arbiter
(
	input  logic                     clk,
	input  logic                     reset,
	rx_record_if.arbiter             reqs [`UART_HUB_CHANNELS],
	input  logic                     full,
	output logic                     wr_en,
	output uart_hub_pkg::rx_record_t wr_record
);

	localparam int N = `UART_HUB_CHANNELS;

	logic [N-1:0]             req_vec;
	logic [N-1:0]             grant_vec;
	uart_hub_pkg::rx_record_t rec_vec [N];

	// Highest priority channel this cycle
	uart_hub_pkg::chan_id_t ptr;
	uart_hub_pkg::chan_id_t sel;
	uart_hub_pkg::chan_id_t cand;
	logic                   found;

	// Flatten the interface array
	for (genvar i = 0; i < N; i++)
	begin : g_port
		assign req_vec[i] = reqs[i].req;
		assign rec_vec[i] = reqs[i].record;
		assign reqs[i].grant = grant_vec[i];
	end

	//////////////////////////////////////////////////////////////////////
	// Round robin pick
	//////////////////////////////////////////////////////////////////////

	always_comb
	begin
		found = 1'b0;
		sel = ptr;
		cand = ptr;
		// Scan from the pointer upward with wrap, first hit wins
		for (int k = 0; k < N; k++)
		begin
			cand = uart_hub_pkg::chan_id_t'((int'(ptr) + k) % N);
			if (!found && req_vec[cand])
			begin
				found = 1'b1;
				sel = cand;
			end
		end
	end

	// No grant while the FIFO is full, write in the grant cycle
	always_comb
	begin
		grant_vec = '0;
		if (found && !full)
			grant_vec[sel] = 1'b1;
	end

	assign wr_en = found & ~full;
	assign wr_record = rec_vec[sel];

	// Step past the granted channel so it cannot starve the others
	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
			ptr <= '0;
		else if (wr_en)
		begin
			if (sel == uart_hub_pkg::chan_id_t'(N - 1))
				ptr <= '0;
			else
				ptr <= sel + 1'b1;
		end
	end

endmodule

//--- source/rx_fifo.sv
`timescale 1ns/10ps
`include "uart_hub_settings.svh"

module rx_fifo
#(
	parameter int DEPTH = `UART_HUB_FIFO_DEPTH
)
(
	input  logic                     clk,
	input  logic                     reset,
	input  logic                     wr_en,
	input  uart_hub_pkg::rx_record_t wr_record,
	output logic                     full,
	output logic                     out_valid,
	input  logic                     out_ready,
	output uart_hub_pkg::rx_record_t out_record
);

	localparam int PTR_W = $clog2(DEPTH);
	localparam int CNT_W = $clog2(DEPTH + 1);

	uart_hub_pkg::rx_record_t mem [DEPTH];

	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] count;

	logic do_write;
	logic do_read;

	assign full = (count == CNT_W'(DEPTH));
	assign out_valid = (count != '0);

	// Head is shown ahead of the read
	assign out_record = mem[rd_ptr];

	assign do_write = wr_en & ~full;
	assign do_read = out_valid & out_ready;

	//////////////////////////////////////////////////////////////////////
	// Storage
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk)
	begin
		if (do_write)
			mem[wr_ptr] <= wr_record;
	end

	// Pointers wrap at DEPTH-1 so any depth works
	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end
		else
		begin
			if (do_write)
				wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			if (do_read)
				rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			// Simultaneous read and write leave the count alone
			if (do_write && !do_read)
				count <= count + 1'b1;
			else if (do_read && !do_write)
				count <= count - 1'b1;
		end
	end

endmodule

//--- source/rx_record_if.sv
`timescale 1ns/10ps

interface rx_record_if;

	// Record pending at the receiver
	logic req;

	// One cycle pulse, record taken
	logic grant;

	// Stable while req is high
	uart_hub_pkg::rx_record_t record;

	// Frame receiver side
	modport receiver
	(
		output req,
		output record,
		input  grant
	);

	// Arbiter side
	modport arbiter
	(
		input  req,
		input  record,
		output grant
	);

endinterface

//--- source/uart_baud_tick.sv
`timescale 1ns/10ps
`include "uart_hub_settings.svh"

module uart_baud_tick
(
	input  logic clk,
	input  logic reset,
	output logic tick
);

	localparam int DIV = `UART_HUB_BAUD_DIV;
	localparam int CNT_W = (DIV > 1) ? $clog2(DIV) : 1;

	// Free running divider
	logic [CNT_W-1:0] div_cnt;

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			div_cnt <= '0;
			tick <= 1'b0;
		end
		else
		begin
			// Wrap at DIV-1, tick is high in the cycle after the wrap
			if (div_cnt == CNT_W'(DIV - 1))
			begin
				div_cnt <= '0;
				tick <= 1'b1;
			end
			else
			begin
				div_cnt <= div_cnt + 1'b1;
				tick <= 1'b0;
			end
		end
	end

endmodule

//--- source/uart_frame_rx.sv
`timescale 1ns/10ps
`include "uart_hub_settings.svh"

module uart_frame_rx
(
	input  logic                   clk,
	input  logic                   reset,
	input  logic                   tick,
	input  logic                   rx,
	input  uart_hub_pkg::chan_id_t chan,
	rx_record_if.receiver          rec
);

	// Tick index of mid start bit, and of the last tick in a bit
	localparam uart_hub_pkg::tick_count_t MID_TICK =
		uart_hub_pkg::tick_count_t'(`UART_HUB_OVERSAMPLE / 2 - 1);
	localparam uart_hub_pkg::tick_count_t LAST_TICK =
		uart_hub_pkg::tick_count_t'(`UART_HUB_OVERSAMPLE - 1);

	uart_hub_pkg::rx_state_t   state, state_next;
	uart_hub_pkg::tick_count_t s_cnt, s_next;
	logic [2:0]                n_cnt, n_next;

	// Line synchronizer and edge detect
	logic rx_meta;
	logic rx_s;
	logic rx_prev;
	logic rx_fall;

	logic                     shift_en;
	logic                     frame_done;
	uart_hub_pkg::data_byte_t b_reg;
	uart_hub_pkg::rx_record_t record_q;
	logic                     req_q;
	logic                     overrun;

	//////////////////////////////////////////////////////////////////////
	// Input line
	//////////////////////////////////////////////////////////////////////

	// Idle line is high
	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			rx_meta <= 1'b1;
			rx_s <= 1'b1;
			rx_prev <= 1'b1;
		end
		else
		begin
			rx_meta <= rx;
			rx_s <= rx_meta;
			rx_prev <= rx_s;
		end
	end

	// Only a high to low edge opens a frame, a line stuck low does not
	assign rx_fall = rx_prev & ~rx_s;

	//////////////////////////////////////////////////////////////////////
	// Frame FSM
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			state <= uart_hub_pkg::rx_idle;
			s_cnt <= '0;
			n_cnt <= '0;
		end
		else
		begin
			state <= state_next;
			s_cnt <= s_next;
			n_cnt <= n_next;
		end
	end

	always_comb
	begin
		state_next = state;
		s_next = s_cnt;
		n_next = n_cnt;
		shift_en = 1'b0;
		frame_done = 1'b0;
		case (state)
			uart_hub_pkg::rx_idle:
				if (rx_fall)
				begin
					state_next = uart_hub_pkg::rx_start;
					s_next = '0;
				end
			uart_hub_pkg::rx_start:
				if (tick)
				begin
					// Eighth tick, middle of the start bit
					if (s_cnt == MID_TICK)
					begin
						s_next = '0;
						n_next = '0;
						// Line back high means a glitch
						if (rx_s)
							state_next = uart_hub_pkg::rx_idle;
						else
							state_next = uart_hub_pkg::rx_data;
					end
					else
						s_next = s_cnt + 1'b1;
				end
			uart_hub_pkg::rx_data:
				if (tick)
				begin
					if (s_cnt == LAST_TICK)
					begin
						s_next = '0;
						shift_en = 1'b1;
						if (n_cnt == 3'd7)
							state_next = uart_hub_pkg::rx_stop;
						else
							n_next = n_cnt + 1'b1;
					end
					else
						s_next = s_cnt + 1'b1;
				end
			uart_hub_pkg::rx_stop:
				if (tick)
				begin
					// Stop sample, the frame is complete here
					if (s_cnt == LAST_TICK)
					begin
						state_next = uart_hub_pkg::rx_idle;
						frame_done = 1'b1;
					end
					else
						s_next = s_cnt + 1'b1;
				end
			default:
				state_next = uart_hub_pkg::rx_idle;
		endcase
	end

	//////////////////////////////////////////////////////////////////////
	// Record hold
	//////////////////////////////////////////////////////////////////////

	// Old record still pending and not taken this cycle
	assign overrun = req_q & ~rec.grant;

	// LSB arrives first, shift in from the top
	always_ff @(posedge clk)
	begin
		if (shift_en)
			b_reg <= {rx_s, b_reg[7:1]};
		if (frame_done)
			record_q <= {overrun, ~rx_s, chan, b_reg};
	end

	// Held until granted, a new frame keeps it up
	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
			req_q <= 1'b0;
		else
			req_q <= frame_done | (req_q & ~rec.grant);
	end

	assign rec.req = req_q;
	assign rec.record = record_q;

endmodule

//--- source/uart_hub.sv
`timescale 1ns/10ps
`include "uart_hub_settings.svh"

module uart_hub
(
	input  logic                          clk,
	input  logic                          reset,
	input  logic [`UART_HUB_CHANNELS-1:0] rx,
	output logic                          out_valid,
	input  logic                          out_ready,
	output uart_hub_pkg::rx_record_t      out_record
);

	// Shared oversample tick
	logic tick;

	// Arbiter to FIFO write side
	logic                     fifo_wr_en;
	uart_hub_pkg::rx_record_t fifo_wr_record;
	logic                     fifo_full;

	// One record channel per receiver
	rx_record_if rec_if [`UART_HUB_CHANNELS] ();

	uart_baud_tick i_baud_tick
	(
		.clk   (clk),
		.reset (reset),
		.tick  (tick)
	);

	// Receiver id is its loop index
	for (genvar g = 0; g < `UART_HUB_CHANNELS; g++)
	begin : g_rx
		uart_frame_rx i_frame_rx
		(
			.clk   (clk),
			.reset (reset),
			.tick  (tick),
			.rx    (rx[g]),
			.chan  (uart_hub_pkg::chan_id_t'(g)),
			.rec   (rec_if[g].receiver)
		);
	end

	rx_buffer_arbiter i_arbiter
	(
		.clk       (clk),
		.reset     (reset),
		.reqs      (rec_if),
		.full      (fifo_full),
		.wr_en     (fifo_wr_en),
		.wr_record (fifo_wr_record)
	);

	rx_fifo #(.DEPTH(`UART_HUB_FIFO_DEPTH)) i_fifo
	(
		.clk        (clk),
		.reset      (reset),
		.wr_en      (fifo_wr_en),
		.wr_record  (fifo_wr_record),
		.full       (fifo_full),
		.out_valid  (out_valid),
		.out_ready  (out_ready),
		.out_record (out_record)
	);

endmodule

//--- source/uart_hub_pkg.sv
`include "uart_hub_settings.svh"

package uart_hub_pkg;

	//////////////////////////////////////////////////////////////////////
	// Payload widths
	//////////////////////////////////////////////////////////////////////

	// One data byte off the line
	typedef logic [7:0] data_byte_t;

	// Source channel of a record
	typedef logic [`UART_HUB_CHAN_W-1:0] chan_id_t;

	// Stored record, from MSB
	// Overrun, framing error, channel id, data byte
	typedef logic [`UART_HUB_CHAN_W+9:0] rx_record_t;

	//////////////////////////////////////////////////////////////////////
	// Receiver control
	//////////////////////////////////////////////////////////////////////

	// Frame receiver states
	typedef enum logic [1:0]
	{
		rx_idle,
		rx_start,
		rx_data,
		rx_stop
	} rx_state_t;

	// Counts oversample ticks within one bit
	typedef logic [3:0] tick_count_t;

endpackage

//--- source/uart_hub_settings.svh
`ifndef UART_HUB_SETTINGS_SVH
`define UART_HUB_SETTINGS_SVH

// Number of serial inputs on the hub
`define UART_HUB_CHANNELS 2

// Bits needed for a channel number
`define UART_HUB_CHAN_W 1

// Clock cycles between two oversample ticks
`define UART_HUB_BAUD_DIV 4

// Oversample ticks per serial bit, one bit is BAUD_DIV * OVERSAMPLE clocks
`define UART_HUB_OVERSAMPLE 16

// Default depth of the shared receive FIFO
`define UART_HUB_FIFO_DEPTH 8

`endif

//--- uart_hub.f
+incdir+source
source/uart_hub_pkg.sv
source/rx_record_if.sv
source/uart_baud_tick.sv
source/uart_frame_rx.sv
source/rx_buffer_arbiter.sv
source/rx_fifo.sv
source/uart_hub.sv
dv/uart_hub_tb.sv
